// ==== csr_unit_defines.svh ====
`ifndef CSR_UNIT_DEFINES_SVH
`define CSR_UNIT_DEFINES_SVH

`define CSR_XLEN                64
`define CSR_ADDR_W              12
`define CSR_INSTR_W             32

// machine information, reads as zero
`define CSR_ADDR_MVENDORID      12'hf11
`define CSR_ADDR_MARCHID        12'hf12
`define CSR_ADDR_MIMPID         12'hf13
`define CSR_ADDR_MHARTID        12'hf14

`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MTVAL          12'h343
`define CSR_ADDR_MIP            12'h344
`define CSR_ADDR_MTINST         12'h34a
`define CSR_ADDR_CYCLE          12'hc00
`define CSR_ADDR_TIME           12'hc01
`define CSR_ADDR_MTIMECMP       12'hbbf

`define CSR_MSTATUS_MIE         3
`define CSR_MSTATUS_MPIE        7
`define CSR_MIE_MTIE            7
`define CSR_MIP_MTIP            7
`define CSR_MIE_MEIE            11
`define CSR_MIP_MEIP            11

// mxl=2, rv64 with a, c, i, m, s and u
`define CSR_MISA_VALUE          64'h8000_0000_0014_1105

`define CSR_CAUSE_INSTR_MISALIGNED  63'h0
`define CSR_CAUSE_ILLEGAL_INSTR     63'h2
`define CSR_CAUSE_EBREAK            63'h3
`define CSR_CAUSE_LW_ACCESS_FAULT   63'h5
`define CSR_CAUSE_SW_ACCESS_FAULT   63'h7
`define CSR_CAUSE_ECALL             63'hb
`define CSR_CAUSE_M_TIMER_IRQ       63'h7
`define CSR_CAUSE_M_EXTERNAL_IRQ    63'hb

`endif

// ==== csr_unit_pkg.sv ====
`include "csr_unit_defines.svh"

package csr_unit_pkg;

    // csr instruction operation, funct3[1:0]
    typedef enum logic [1:0]
    {
        CSR_OP_NONE = 2'h0,
        CSR_OP_RW   = 2'h1,
        CSR_OP_RS   = 2'h2,
        CSR_OP_RC   = 2'h3
    } csr_op_e;

    typedef enum logic
    {
        TRAP_IDLE,
        TRAP_SETUP
    } trap_state_e;

    // mcause layout
    typedef struct packed
    {
        logic                   irq;
        logic [`CSR_XLEN-2:0]   code;
    } trap_cause_t;

endpackage

// ==== csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_unit_defines.svh"

module csr_timer
(
    input  logic                    i_csr_unit_clk,
    input  logic                    i_csr_unit_rst_n,
    input  logic [`CSR_XLEN-1:0]    i_mtimecmp,
    output logic [`CSR_XLEN-1:0]    o_counter,
    output logic                    o_mtip
);

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            o_counter <= '0;
            o_mtip    <= 1'b0;
        end
        else
        begin
            o_counter <= o_counter + 1'b1;          // cycle and time share it
            o_mtip    <= (o_counter >= i_mtimecmp); // one edge behind counter
        end
    end

endmodule

// ==== csr_machine_regs.sv ====
`timescale 1ns/1ps
`include "csr_unit_defines.svh"

module csr_machine_regs
(
    input  logic                        i_csr_unit_clk,
    input  logic                        i_csr_unit_rst_n,
    input  logic                        i_csr_wen,
    input  logic                        i_mret,
    input  csr_unit_pkg::csr_op_e       i_op,
    input  logic [`CSR_XLEN-1:0]        i_src,
    input  logic [`CSR_ADDR_W-1:0]      i_csr_addr,
    input  logic                        i_mexternal,
    input  logic [`CSR_XLEN-1:0]        i_counter,
    input  logic                        i_mtip,
    input  logic                        i_trap_take,
    input  logic                        i_trap_setup,
    input  csr_unit_pkg::trap_cause_t   i_trap_cause,
    input  logic [`CSR_XLEN-1:0]        i_trap_pc,
    input  logic [`CSR_XLEN-1:0]        i_trap_tval,
    input  logic [`CSR_INSTR_W-1:0]     i_trap_tinst,
    output logic [`CSR_XLEN-1:0]        o_rdata,
    output logic [`CSR_XLEN-1:0]        o_mtimecmp,
    output logic [`CSR_XLEN-1:0]        o_mtvec,
    output logic [`CSR_XLEN-1:0]        o_mepc,
    output csr_unit_pkg::trap_cause_t   o_mcause,
    output logic                        o_irq_ext_en,
    output logic                        o_irq_tmr_en
);

    import csr_unit_pkg::*;

    logic                       mstatus_mie;
    logic                       mstatus_mpie;
    logic                       mie_meie;
    logic                       mie_mtie;
    logic                       mip_meip;
    logic [`CSR_XLEN-1:0]       mtvec;
    logic [`CSR_XLEN-1:0]       mscratch;
    logic [`CSR_XLEN-1:0]       mtimecmp;
    logic [`CSR_XLEN-1:0]       mepc;
    trap_cause_t                mcause;
    logic [`CSR_XLEN-1:0]       mtval;
    logic [`CSR_INSTR_W-1:0]    mtinst;

    logic [`CSR_XLEN-1:0]       mstatus_rd;
    logic [`CSR_XLEN-1:0]       mie_rd;
    logic [`CSR_XLEN-1:0]       mip_rd;
    logic [`CSR_XLEN-1:0]       op_result;
    logic                       csr_write;
    logic                       mret_upd;

    assign csr_write = i_csr_wen & ~i_mret;
    assign mret_upd  = i_csr_wen & i_mret;

    always_comb
    begin
        mstatus_rd = '0;
        mstatus_rd[12:11] = 2'b11;  // mpp, machine mode only
        mstatus_rd[`CSR_MSTATUS_MIE]  = mstatus_mie;
        mstatus_rd[`CSR_MSTATUS_MPIE] = mstatus_mpie;
        mie_rd = '0;
        mie_rd[`CSR_MIE_MEIE] = mie_meie;
        mie_rd[`CSR_MIE_MTIE] = mie_mtie;
        mip_rd = '0;
        mip_rd[`CSR_MIP_MEIP] = mip_meip;
        mip_rd[`CSR_MIP_MTIP] = i_mtip;
    end

    always_comb
    begin
        case (i_csr_addr)
            `CSR_ADDR_MVENDORID,
            `CSR_ADDR_MARCHID,
            `CSR_ADDR_MIMPID,
            `CSR_ADDR_MHARTID:  o_rdata = '0;
            `CSR_ADDR_MISA:     o_rdata = `CSR_MISA_VALUE;
            `CSR_ADDR_MSTATUS:  o_rdata = mstatus_rd;
            `CSR_ADDR_MIE:      o_rdata = mie_rd;
            `CSR_ADDR_MIP:      o_rdata = mip_rd;
            `CSR_ADDR_MTVEC:    o_rdata = mtvec;
            `CSR_ADDR_MSCRATCH: o_rdata = mscratch;
            `CSR_ADDR_MEPC:     o_rdata = mepc;
            `CSR_ADDR_MCAUSE:   o_rdata = mcause;
            `CSR_ADDR_MTVAL:    o_rdata = mtval;
            `CSR_ADDR_MTINST:   o_rdata = {{(`CSR_XLEN-`CSR_INSTR_W){1'b0}}, mtinst};
            `CSR_ADDR_CYCLE,
            `CSR_ADDR_TIME:     o_rdata = i_counter;
            `CSR_ADDR_MTIMECMP: o_rdata = mtimecmp;
            default:            o_rdata = '0;
        endcase
    end

    always_comb
    begin
        case (i_op)
            CSR_OP_RW: op_result = i_src;
            CSR_OP_RS: op_result = o_rdata | i_src;
            CSR_OP_RC: op_result = o_rdata & ~i_src;
            default:   op_result = o_rdata;    // no op keeps the old value
        endcase
    end

    // status, enables and setup registers
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mip_meip     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mtimecmp     <= '0;
        end
        else
        begin
            mip_meip <= i_mexternal;
            if (mret_upd)
            begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
            else if (csr_write)
            begin
                case (i_csr_addr)
                    `CSR_ADDR_MSTATUS:
                    begin
                        mstatus_mie  <= op_result[`CSR_MSTATUS_MIE];
                        mstatus_mpie <= op_result[`CSR_MSTATUS_MPIE];
                    end
                    `CSR_ADDR_MIE:
                    begin
                        mie_meie <= op_result[`CSR_MIE_MEIE];
                        mie_mtie <= op_result[`CSR_MIE_MTIE];
                    end
                    `CSR_ADDR_MTVEC:    mtvec    <= op_result;
                    `CSR_ADDR_MSCRATCH: mscratch <= op_result;
                    `CSR_ADDR_MTIMECMP: mtimecmp <= op_result;
                    default: ;
                endcase
            end
            if (i_trap_setup)   // second edge of trap entry
            begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end
        end
    end

    // trap record, trap beats a csr write
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
            mtinst <= '0;
        end
        else if (i_trap_take)
        begin
            mepc   <= i_trap_pc;
            mcause <= i_trap_cause;
            mtval  <= i_trap_tval;
            mtinst <= i_trap_tinst;
        end
        else if (csr_write)
        begin
            case (i_csr_addr)
                `CSR_ADDR_MEPC:   mepc   <= op_result;
                `CSR_ADDR_MCAUSE: mcause <= trap_cause_t'(op_result);
                `CSR_ADDR_MTVAL:  mtval  <= op_result;
                `CSR_ADDR_MTINST: mtinst <= op_result[`CSR_INSTR_W-1:0];
                default: ;
            endcase
        end
    end

    assign o_irq_ext_en = mstatus_mie & mie_meie & mip_meip;
    assign o_irq_tmr_en = mstatus_mie & mie_mtie & i_mtip;

    assign o_mtimecmp = mtimecmp;
    assign o_mtvec    = mtvec;
    assign o_mepc     = mepc;
    assign o_mcause   = mcause;

endmodule

// ==== csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_unit_defines.svh"

module csr_trap_ctrl
(
    input  logic                        i_csr_unit_clk,
    input  logic                        i_csr_unit_rst_n,
    input  logic                        i_irq_ext_en,
    input  logic                        i_irq_tmr_en,
    input  logic                        i_illegal_instr_id,
    input  logic                        i_illegal_instr_exe,
    input  logic                        i_instr_addr_misaligned,
    input  logic                        i_ecall,
    input  logic                        i_ebreak,
    input  logic                        i_sw_access_fault,
    input  logic                        i_lw_access_fault,
    input  logic [`CSR_XLEN-1:0]        i_fault_addr,
    input  logic [`CSR_INSTR_W-1:0]     i_instr,
    input  logic                        i_mret,
    input  logic [`CSR_XLEN-1:0]        i_mtvec,
    input  logic [`CSR_XLEN-1:0]        i_mepc,
    input  csr_unit_pkg::trap_cause_t   i_mcause,
    output logic                        o_trap_take,
    output logic                        o_trap_setup,
    output csr_unit_pkg::trap_cause_t   o_trap_cause,
    output logic [`CSR_XLEN-1:0]        o_trap_tval,
    output logic [`CSR_INSTR_W-1:0]     o_trap_tinst,
    output logic                        o_ack,
    output logic [`CSR_XLEN-1:0]        o_irq_handler,
    output logic [`CSR_XLEN-1:0]        o_rtrn_addr,
    output logic                        o_addr_ctrl,
    output logic                        o_mux1
);

    import csr_unit_pkg::*;

    trap_state_e            state;
    logic                   trap_req;
    logic [`CSR_XLEN-1:0]   tvec_base;
    logic [`CSR_XLEN-1:0]   vec_offset;

    // fixed priority, interrupts first
    always_comb
    begin
        trap_req     = 1'b1;
        o_trap_cause = '0;
        o_trap_tval  = '0;
        o_trap_tinst = i_instr;
        if (i_irq_ext_en)
        begin
            o_trap_cause = '{irq: 1'b1, code: `CSR_CAUSE_M_EXTERNAL_IRQ};
            o_trap_tinst = '0;
        end
        else if (i_irq_tmr_en)
        begin
            o_trap_cause = '{irq: 1'b1, code: `CSR_CAUSE_M_TIMER_IRQ};
            o_trap_tinst = '0;
        end
        else if (i_illegal_instr_id | i_illegal_instr_exe)
            o_trap_cause.code = `CSR_CAUSE_ILLEGAL_INSTR;
        else if (i_instr_addr_misaligned)
            o_trap_cause.code = `CSR_CAUSE_INSTR_MISALIGNED;
        else if (i_ecall)
            o_trap_cause.code = `CSR_CAUSE_ECALL;
        else if (i_ebreak)
            o_trap_cause.code = `CSR_CAUSE_EBREAK;
        else if (i_sw_access_fault)
        begin
            o_trap_cause.code = `CSR_CAUSE_SW_ACCESS_FAULT;
            o_trap_tval       = i_fault_addr;
        end
        else if (i_lw_access_fault)
        begin
            o_trap_cause.code = `CSR_CAUSE_LW_ACCESS_FAULT;
            o_trap_tval       = i_fault_addr;
        end
        else
            trap_req = 1'b0;
    end

    assign o_trap_take  = trap_req & (state == TRAP_IDLE);  // no nesting
    assign o_trap_setup = (state == TRAP_SETUP);

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            state <= TRAP_IDLE;
            o_ack <= 1'b0;
        end
        else
        begin
            state <= o_trap_take ? TRAP_SETUP : TRAP_IDLE;
            o_ack <= o_trap_take & i_irq_ext_en;    // high for the setup cycle only
        end
    end

    assign tvec_base  = {i_mtvec[`CSR_XLEN-1:1], 1'b0};
    assign vec_offset = {i_mcause.code[`CSR_XLEN-3:0], 2'b00};

    always_comb
    begin
        if (!i_mtvec[0])
            o_irq_handler = i_mtvec;                    // direct
        else if (i_mcause.irq)
            o_irq_handler = tvec_base + vec_offset;
        else
            o_irq_handler = tvec_base;
    end

    assign o_rtrn_addr = i_mepc;
    assign o_addr_ctrl = i_mret;
    assign o_mux1      = o_trap_setup | i_mret;

endmodule

// ==== riscv_core_csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_unit_defines.svh"

module riscv_core_csr_unit
(
    input  logic                        i_csr_unit_clk,
    input  logic                        i_csr_unit_rst_n,
    input  logic [`CSR_XLEN-1:0]        i_csr_unit_pc,
    input  logic [`CSR_XLEN-1:0]        i_csr_unit_fault_addr,  // load/store fault address
    input  logic [`CSR_INSTR_W-1:0]     i_csr_unit_instr,
    input  logic                        i_csr_unit_mexternal,
    output logic                        o_csr_unit_ack,
    input  logic                        i_csr_unit_csr_wen,
    input  csr_unit_pkg::csr_op_e       i_csr_unit_op,
    input  logic [`CSR_XLEN-1:0]        i_csr_unit_src,
    input  logic [`CSR_ADDR_W-1:0]      i_csr_unit_csr_addr,
    output logic [`CSR_XLEN-1:0]        o_csr_unit_csr_rdata,
    output logic [`CSR_XLEN-1:0]        o_csr_unit_irq_handler,
    output logic [`CSR_XLEN-1:0]        o_csr_unit_rtrn_addr,
    output logic                        o_csr_unit_addr_ctrl,   // mepc vs handler select
    output logic                        o_csr_unit_mux1,
    input  logic                        i_csr_unit_mret_wb,
    input  logic                        i_csr_unit_ecall,
    input  logic                        i_csr_unit_ebreak,
    input  logic                        i_csr_unit_illegal_instr_id,
    input  logic                        i_csr_unit_illegal_instr_exe,
    input  logic                        i_csr_unit_instr_addr_misaligned,
    input  logic                        i_csr_unit_lw_access_fault,
    input  logic                        i_csr_unit_sw_access_fault
);

    import csr_unit_pkg::*;

    logic [`CSR_XLEN-1:0]       counter;
    logic                       mtip;
    logic [`CSR_XLEN-1:0]       mtimecmp;
    logic [`CSR_XLEN-1:0]       mtvec;
    logic [`CSR_XLEN-1:0]       mepc;
    trap_cause_t                mcause;
    logic                       irq_ext_en;
    logic                       irq_tmr_en;
    logic                       trap_take;
    logic                       trap_setup;
    trap_cause_t                trap_cause;
    logic [`CSR_XLEN-1:0]       trap_tval;
    logic [`CSR_INSTR_W-1:0]    trap_tinst;

    csr_timer timer_i
    (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_mtimecmp       (mtimecmp),
        .o_counter        (counter),
        .o_mtip           (mtip)
    );

    csr_machine_regs regs_i
    (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_csr_wen        (i_csr_unit_csr_wen),
        .i_mret           (i_csr_unit_mret_wb),
        .i_op             (i_csr_unit_op),
        .i_src            (i_csr_unit_src),
        .i_csr_addr       (i_csr_unit_csr_addr),
        .i_mexternal      (i_csr_unit_mexternal),
        .i_counter        (counter),
        .i_mtip           (mtip),
        .i_trap_take      (trap_take),
        .i_trap_setup     (trap_setup),
        .i_trap_cause     (trap_cause),
        .i_trap_pc        (i_csr_unit_pc),
        .i_trap_tval      (trap_tval),
        .i_trap_tinst     (trap_tinst),
        .o_rdata          (o_csr_unit_csr_rdata),
        .o_mtimecmp       (mtimecmp),
        .o_mtvec          (mtvec),
        .o_mepc           (mepc),
        .o_mcause         (mcause),
        .o_irq_ext_en     (irq_ext_en),
        .o_irq_tmr_en     (irq_tmr_en)
    );

    csr_trap_ctrl trap_i
    (
        .i_csr_unit_clk          (i_csr_unit_clk),
        .i_csr_unit_rst_n        (i_csr_unit_rst_n),
        .i_irq_ext_en            (irq_ext_en),
        .i_irq_tmr_en            (irq_tmr_en),
        .i_illegal_instr_id      (i_csr_unit_illegal_instr_id),
        .i_illegal_instr_exe     (i_csr_unit_illegal_instr_exe),
        .i_instr_addr_misaligned (i_csr_unit_instr_addr_misaligned),
        .i_ecall                 (i_csr_unit_ecall),
        .i_ebreak                (i_csr_unit_ebreak),
        .i_sw_access_fault       (i_csr_unit_sw_access_fault),
        .i_lw_access_fault       (i_csr_unit_lw_access_fault),
        .i_fault_addr            (i_csr_unit_fault_addr),
        .i_instr                 (i_csr_unit_instr),
        .i_mret                  (i_csr_unit_mret_wb),
        .i_mtvec                 (mtvec),
        .i_mepc                  (mepc),
        .i_mcause                (mcause),
        .o_trap_take             (trap_take),
        .o_trap_setup            (trap_setup),
        .o_trap_cause            (trap_cause),
        .o_trap_tval             (trap_tval),
        .o_trap_tinst            (trap_tinst),
        .o_ack                   (o_csr_unit_ack),
        .o_irq_handler           (o_csr_unit_irq_handler),
        .o_rtrn_addr             (o_csr_unit_rtrn_addr),
        .o_addr_ctrl             (o_csr_unit_addr_ctrl),
        .o_mux1                  (o_csr_unit_mux1)
    );

endmodule

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_unit_defines.svh"

module tb_csr_unit;

    import csr_unit_pkg::*;

    localparam int          TEST_CYCLES = 300;  // whole sequence, with slack
    localparam int          MARGIN_NS   = 1000;
    localparam logic [63:0] TVEC_BASE   = 64'h0000_0000_8000_0100;
    // {illegal_id, illegal_exe, misaligned, ecall, ebreak, sw_fault, lw_fault}
    localparam logic [6:0]  EXC_MASKS [10] = '{7'h40, 7'h20, 7'h10, 7'h08, 7'h04,
                                               7'h02, 7'h01, 7'h0a, 7'h11, 7'h03};

    logic           clk;
    logic           rst_n;
    logic [63:0]    pc;
    logic [63:0]    fault_addr;
    logic [31:0]    instr;
    logic           mexternal;
    logic           ack;
    logic           csr_wen;
    csr_op_e        op;
    logic [63:0]    src;
    logic [11:0]    csr_addr;
    logic [63:0]    rdata;
    logic [63:0]    irq_handler;
    logic [63:0]    rtrn_addr;
    logic           addr_ctrl;
    logic           mux1;
    logic           mret_wb;
    logic           ecall;
    logic           ebreak;
    logic           illegal_id;
    logic           illegal_exe;
    logic           misaligned;
    logic           lw_fault;
    logic           sw_fault;

    logic [31:0]    rng_state;
    int             checks;
    int             errors;
    int             prop_errors;

    // reference model of the machine registers
    logic           m_mie;
    logic           m_mpie;
    logic           m_meie;
    logic           m_mtie;
    logic [63:0]    m_mtvec;
    logic [63:0]    m_mscratch;
    logic [63:0]    m_mepc;
    logic [63:0]    m_mcause;
    logic [63:0]    m_mtval;
    logic [63:0]    m_mtimecmp;

    riscv_core_csr_unit dut_i
    (
        .i_csr_unit_clk                   (clk),
        .i_csr_unit_rst_n                 (rst_n),
        .i_csr_unit_pc                    (pc),
        .i_csr_unit_fault_addr            (fault_addr),
        .i_csr_unit_instr                 (instr),
        .i_csr_unit_mexternal             (mexternal),
        .o_csr_unit_ack                   (ack),
        .i_csr_unit_csr_wen               (csr_wen),
        .i_csr_unit_op                    (op),
        .i_csr_unit_src                   (src),
        .i_csr_unit_csr_addr              (csr_addr),
        .o_csr_unit_csr_rdata             (rdata),
        .o_csr_unit_irq_handler           (irq_handler),
        .o_csr_unit_rtrn_addr             (rtrn_addr),
        .o_csr_unit_addr_ctrl             (addr_ctrl),
        .o_csr_unit_mux1                  (mux1),
        .i_csr_unit_mret_wb               (mret_wb),
        .i_csr_unit_ecall                 (ecall),
        .i_csr_unit_ebreak                (ebreak),
        .i_csr_unit_illegal_instr_id      (illegal_id),
        .i_csr_unit_illegal_instr_exe     (illegal_exe),
        .i_csr_unit_instr_addr_misaligned (misaligned),
        .i_csr_unit_lw_access_fault       (lw_fault),
        .i_csr_unit_sw_access_fault       (sw_fault)
    );

    always #10 clk = ~clk;

    initial
    begin
        #(TEST_CYCLES * 20 + MARGIN_NS);
        $display("watchdog expired, the test did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ack may only be high while the trap is being set up
    ack_in_setup: assert property (@(posedge clk) disable iff (!rst_n) ack |-> mux1)
    else
    begin
        prop_errors++;
        $display("ack was high at %0t ns outside the trap setup cycle", $time);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [63:0] v);
        rng_state = xorshift32(rng_state);
        v[63:32]  = rng_state;
        rng_state = xorshift32(rng_state);
        v[31:0]   = rng_state;
    endtask

    function automatic logic [63:0] model_read(input logic [11:0] addr);
        logic [63:0] v;
        v = '0;
        case (addr)
            // mxl=2 with a, c, i, m, s, u
            `CSR_ADDR_MISA:     v = (64'h2 << 62) | 64'h1 | (64'h1 << 2) | (64'h1 << 8)
                                    | (64'h1 << 12) | (64'h1 << 18) | (64'h1 << 20);
            `CSR_ADDR_MSTATUS:  v = (64'h3 << 11) | (64'(m_mpie) << 7) | (64'(m_mie) << 3);
            `CSR_ADDR_MIE:      v = (64'(m_meie) << 11) | (64'(m_mtie) << 7);
            `CSR_ADDR_MTVEC:    v = m_mtvec;
            `CSR_ADDR_MSCRATCH: v = m_mscratch;
            `CSR_ADDR_MEPC:     v = m_mepc;
            `CSR_ADDR_MCAUSE:   v = m_mcause;
            `CSR_ADDR_MTVAL:    v = m_mtval;
            `CSR_ADDR_MTIMECMP: v = m_mtimecmp;
            default:            v = '0;    // id registers and unmapped
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [11:0] addr, input csr_op_e o, input logic [63:0] d);
        logic [63:0] old_v;
        logic [63:0] new_v;
        old_v = model_read(addr);
        case (o)
            CSR_OP_RW: new_v = d;
            CSR_OP_RS: new_v = old_v | d;
            CSR_OP_RC: new_v = old_v & ~d;
            default:   new_v = old_v;
        endcase
        case (addr)
            `CSR_ADDR_MSTATUS:
            begin
                m_mie  = new_v[3];
                m_mpie = new_v[7];
            end
            `CSR_ADDR_MIE:
            begin
                m_meie = new_v[11];
                m_mtie = new_v[7];
            end
            `CSR_ADDR_MTVEC:    m_mtvec    = new_v;
            `CSR_ADDR_MSCRATCH: m_mscratch = new_v;
            `CSR_ADDR_MTIMECMP: m_mtimecmp = new_v;
            default: ;
        endcase
    endtask

    // both trap entry edges at once
    task automatic enter_trap_model(input logic [63:0] epc, input logic [63:0] cause,
                                    input logic [63:0] tval);
        m_mepc   = epc;
        m_mcause = cause;
        m_mtval  = tval;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    endtask

    // highest set bit wins, bit 6 ranks first
    function automatic int winning_strobe(input logic [6:0] mask);
        int win;
        win = -1;
        for (int i = 0; i < 7; i++)
            if (mask[i])
                win = i;
        return win;
    endfunction

    function automatic logic [63:0] exception_code(input int idx);
        logic [63:0] c;
        case (idx)
            6, 5:    c = 64'd2;     // illegal instruction
            4:       c = 64'd0;
            3:       c = 64'd11;
            2:       c = 64'd3;
            1:       c = 64'd7;
            default: c = 64'd5;
        endcase
        return c;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic csr_write(input logic [11:0] addr, input csr_op_e o, input logic [63:0] d);
        @(negedge clk);
        csr_addr = addr;
        op       = o;
        src      = d;
        csr_wen  = 1'b1;
        model_write(addr, o, d);
        @(negedge clk);
        csr_wen  = 1'b0;
        op       = CSR_OP_NONE;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [63:0] d);
        @(negedge clk);
        csr_addr = addr;
        #1;
        d = rdata;
    endtask

    task automatic check_csr(input string name, input logic [11:0] addr);
        logic [63:0] got;
        csr_read(addr, got);
        check_value(name, model_read(addr), got);
    endtask

    task automatic take_exception(input logic [6:0] mask, input logic [63:0] pc_v,
                                  input logic [63:0] addr_v, input logic [31:0] instr_v);
        int          win;
        logic [63:0] exp_tval;
        win      = winning_strobe(mask);
        exp_tval = (win <= 1) ? addr_v : 64'h0;    // access faults only
        @(negedge clk);
        pc         = pc_v;
        fault_addr = addr_v;
        instr      = instr_v;
        {illegal_id, illegal_exe, misaligned, ecall, ebreak, sw_fault, lw_fault} = mask;
        @(negedge clk);
        {illegal_id, illegal_exe, misaligned, ecall, ebreak, sw_fault, lw_fault} = 7'h0;
        check_value("mepc", pc_v, dut_i.regs_i.mepc);
        check_value("mcause", exception_code(win), dut_i.regs_i.o_mcause);
        check_value("mtval", exp_tval, dut_i.regs_i.mtval);
        check_value("mtinst", {32'h0, instr_v}, {32'h0, dut_i.regs_i.mtinst});
        check_value("o_csr_unit_mux1", 64'h1, {63'h0, mux1});
        check_value("o_csr_unit_ack", 64'h0, {63'h0, ack});    // external only
        enter_trap_model(pc_v, exception_code(win), exp_tval);
        check_csr("mstatus", `CSR_ADDR_MSTATUS);
        check_value("o_csr_unit_mux1", 64'h0, {63'h0, mux1});
        csr_write(`CSR_ADDR_MSTATUS, CSR_OP_RS, 64'h1 << 3);   // mie back on
    endtask

    task automatic wait_for_setup(input int limit, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++)
        begin
            @(negedge clk);
            if (mux1)
                seen = 1'b1;
            else
                check_value("o_csr_unit_ack", 64'h0, {63'h0, ack});
        end
    endtask

    initial
    begin
        logic [63:0] got;
        logic [63:0] first;
        logic [63:0] r;
        logic [63:0] fa;
        logic        seen;
        clk = 1'b0;
        rst_n = 1'b0;
        {pc, fault_addr, instr, src} = '0;
        {mexternal, csr_wen, mret_wb, ecall, ebreak} = '0;
        {illegal_id, illegal_exe, misaligned, lw_fault, sw_fault} = '0;
        op = CSR_OP_NONE;
        csr_addr = '0;
        rng_state = 32'hcd74ce9b;
        {checks, errors, prop_errors} = '0;
        {m_mie, m_mpie, m_meie, m_mtie} = '0;
        {m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval, m_mtimecmp} = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        check_csr("misa", `CSR_ADDR_MISA);
        check_csr("mstatus", `CSR_ADDR_MSTATUS);
        check_csr("mvendorid", `CSR_ADDR_MVENDORID);
        check_csr("marchid", `CSR_ADDR_MARCHID);
        check_csr("mimpid", `CSR_ADDR_MIMPID);
        check_csr("mhartid", `CSR_ADDR_MHARTID);
        for (int i = 0; i < 2; i++)
            for (int j = 1; j < 4; j++)
            begin
                next_random(r);
                csr_write(i ? `CSR_ADDR_MTVEC : `CSR_ADDR_MSCRATCH, csr_op_e'(j), r);
                check_csr(i ? "mtvec" : "mscratch", i ? `CSR_ADDR_MTVEC : `CSR_ADDR_MSCRATCH);
            end

        csr_read(`CSR_ADDR_CYCLE, first);
        csr_read(`CSR_ADDR_TIME, got);
        check_value("time - cycle", 64'd1, got - first);
        csr_read(`CSR_ADDR_CYCLE, first);
        repeat (8) @(negedge clk);
        csr_read(`CSR_ADDR_CYCLE, got);
        check_value("cycle delta", 64'd9, got - first);

        csr_write(`CSR_ADDR_MSTATUS, CSR_OP_RS, 64'h1 << 3);
        for (int k = 0; k < 10; k++)
        begin
            next_random(r);
            next_random(fa);
            take_exception(EXC_MASKS[k], {r[63:2], 2'b00}, fa, r[31:0]);
        end

        // timer interrupt, vectored then direct
        csr_write(`CSR_ADDR_MTVEC, CSR_OP_RW, TVEC_BASE | 64'h1);
        csr_read(`CSR_ADDR_CYCLE, got);
        csr_write(`CSR_ADDR_MTIMECMP, CSR_OP_RW, got + 64'd24);
        csr_write(`CSR_ADDR_MIE, CSR_OP_RS, 64'h1 << 7);
        pc = 64'h0000_0000_0000_2000;
        wait_for_setup(64, seen);
        if (!seen)
        begin
            errors++;
            $display("timer interrupt was not taken within 64 cycles");
        end
        else
        begin
            enter_trap_model(pc, {1'b1, 63'd7}, 64'h0);
            check_value("mcause", m_mcause, dut_i.regs_i.o_mcause);
            check_value("o_csr_unit_irq_handler", TVEC_BASE + 64'd28, irq_handler);
            check_value("o_csr_unit_ack", 64'h0, {63'h0, ack});
        end
        check_csr("mstatus", `CSR_ADDR_MSTATUS);
        csr_write(`CSR_ADDR_MTVEC, CSR_OP_RW, TVEC_BASE);
        check_csr("mtvec", `CSR_ADDR_MTVEC);
        check_value("o_csr_unit_irq_handler", m_mtvec, irq_handler);

        // external against a pending timer
        csr_write(`CSR_ADDR_MIE, CSR_OP_RS, 64'h1 << 11);
        @(negedge clk);
        mexternal = 1'b1;
        pc = 64'h0000_0000_0000_3000;
        @(negedge clk);
        csr_write(`CSR_ADDR_MSTATUS, CSR_OP_RS, 64'h1 << 3);
        wait_for_setup(8, seen);
        if (!seen)
        begin
            errors++;
            $display("external interrupt was not taken within 8 cycles");
        end
        else
        begin
            enter_trap_model(pc, {1'b1, 63'd11}, 64'h0);
            check_value("mcause", m_mcause, dut_i.regs_i.o_mcause);
            check_value("o_csr_unit_ack", 64'h1, {63'h0, ack});
        end
        mexternal = 1'b0;
        @(negedge clk);
        check_value("o_csr_unit_ack", 64'h0, {63'h0, ack});
        check_value("o_csr_unit_mux1", 64'h0, {63'h0, mux1});
        check_csr("mstatus", `CSR_ADDR_MSTATUS);
        csr_write(`CSR_ADDR_MIE, CSR_OP_RW, 64'h0);

        @(negedge clk);
        csr_wen = 1'b1;
        mret_wb = 1'b1;
        #1;
        check_value("o_csr_unit_rtrn_addr", m_mepc, rtrn_addr);
        check_value("o_csr_unit_addr_ctrl", 64'h1, {63'h0, addr_ctrl});
        check_value("o_csr_unit_mux1", 64'h1, {63'h0, mux1});
        @(negedge clk);
        csr_wen = 1'b0;
        mret_wb = 1'b0;
        m_mie  = m_mpie;
        m_mpie = 1'b1;
        check_csr("mstatus", `CSR_ADDR_MSTATUS);
        check_csr("mepc", `CSR_ADDR_MEPC);
        check_csr("mcause", `CSR_ADDR_MCAUSE);
        check_csr("mtval", `CSR_ADDR_MTVAL);
        check_csr("mtimecmp", `CSR_ADDR_MTIMECMP);

        $display("checks %0d, value errors %0d, property errors %0d",
                 checks, errors, prop_errors);
        if (errors == 0 && prop_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
csr_unit_pkg.sv
csr_timer.sv
csr_machine_regs.sv
csr_trap_ctrl.sv
riscv_core_csr_unit.sv
tb_csr_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_csr_unit
RTL_TOP   ?= riscv_core_csr_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) csr_unit_defines.svh
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
